//--- compile.f
+incdir+include
source/ipipe_pkg.sv
source/insn_decode.sv
source/reg_file.sv
source/operand_muxes.sv
source/alu.sv
source/writeback_stage.sv
source/int_pipe_top.sv
testbench/int_pipe_tb.sv

//--- include/int_pipe_tb_vectors.svh
`ifndef INT_PIPE_TB_VECTORS_SVH
`define INT_PIPE_TB_VECTORS_SVH

// Each instruction row gives test, op, rd, ra, rb, imm, expected rd and expected data
// add_nops(n) gives idle cycles and add_holds(n) gives cycles with hold high
// Expected data follows in-order execution with all registers zero after reset
task automatic load_vectors();
	// Immediate loads through r0 with negative immediates sign-extended
	add_insn(1, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h0005, 3'd1, 32'h0000_0005);
	add_nops(1);
	add_insn(2, ipipe_pkg::op_addi, 3'd2, 3'd0, 3'd0, 16'hfffd, 3'd2, 32'hffff_fffd);
	add_nops(1);
	add_insn(3, ipipe_pkg::op_addi, 3'd3, 3'd0, 3'd0, 16'h8000, 3'd3, 32'hffff_8000);
	add_nops(1);
	// Write to r0 shows on the result port but never lands
	add_insn(4, ipipe_pkg::op_addi, 3'd0, 3'd0, 3'd0, 16'h0077, 3'd0, 32'h0000_0077);
	add_insn(5, ipipe_pkg::op_add, 3'd4, 3'd0, 3'd0, 16'h0000, 3'd4, 32'h0000_0000);
	add_insn(6, ipipe_pkg::op_addi, 3'd5, 3'd0, 3'd0, 16'h7fff, 3'd5, 32'h0000_7fff);
	// r6 untouched since reset
	add_insn(7, ipipe_pkg::op_or, 3'd7, 3'd6, 3'd6, 16'h0000, 3'd7, 32'h0000_0000);
	add_nops(2);

	// Register-register operations with sources from the register file
	add_insn(8, ipipe_pkg::op_add, 3'd6, 3'd1, 3'd5, 16'h0000, 3'd6, 32'h0000_8004);
	add_nops(2);
	add_insn(9, ipipe_pkg::op_sub, 3'd7, 3'd1, 3'd5, 16'h0000, 3'd7, 32'hffff_8006);
	add_nops(2);
	add_insn(10, ipipe_pkg::op_and, 3'd4, 3'd2, 3'd3, 16'h0000, 3'd4, 32'hffff_8000);
	add_nops(2);
	add_insn(11, ipipe_pkg::op_or, 3'd4, 3'd1, 3'd3, 16'h0000, 3'd4, 32'hffff_8005);
	add_nops(2);
	add_insn(12, ipipe_pkg::op_xor, 3'd6, 3'd2, 3'd5, 16'h0000, 3'd6, 32'hffff_8002);
	add_nops(2);
	// Subtract wraps below zero and reads r0 after the earlier r0 write
	add_insn(13, ipipe_pkg::op_sub, 3'd7, 3'd0, 3'd1, 16'h0000, 3'd7, 32'hffff_fffb);
	add_nops(2);

	// Back-to-back dependents use execute forwarding on A and B
	add_insn(14, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h0010, 3'd1, 32'h0000_0010);
	add_insn(15, ipipe_pkg::op_add, 3'd2, 3'd1, 3'd1, 16'h0000, 3'd2, 32'h0000_0020);
	add_insn(16, ipipe_pkg::op_sub, 3'd3, 3'd2, 3'd1, 16'h0000, 3'd3, 32'h0000_0010);
	add_insn(17, ipipe_pkg::op_or, 3'd4, 3'd3, 3'd2, 16'h0000, 3'd4, 32'h0000_0030);
	add_nops(3);

	// One unrelated instruction between producer and consumer
	add_insn(18, ipipe_pkg::op_addi, 3'd5, 3'd0, 3'd0, 16'h0123, 3'd5, 32'h0000_0123);
	add_insn(19, ipipe_pkg::op_addi, 3'd6, 3'd0, 3'd0, 16'h0456, 3'd6, 32'h0000_0456);
	add_insn(20, ipipe_pkg::op_add, 3'd7, 3'd5, 3'd5, 16'h0000, 3'd7, 32'h0000_0246);
	add_insn(21, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h00f0, 3'd1, 32'h0000_00f0);
	add_insn(22, ipipe_pkg::op_addi, 3'd2, 3'd0, 3'd0, 16'h000f, 3'd2, 32'h0000_000f);
	add_insn(23, ipipe_pkg::op_xor, 3'd3, 3'd4, 3'd1, 16'h0000, 3'd3, 32'h0000_00c0);
	add_nops(3);

	// Freeze between and across dependent pairs
	add_insn(24, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h1000, 3'd1, 32'h0000_1000);
	add_holds(3);
	add_insn(25, ipipe_pkg::op_add, 3'd2, 3'd1, 3'd3, 16'h0000, 3'd2, 32'h0000_10c0);
	add_holds(2);
	add_insn(26, ipipe_pkg::op_sub, 3'd3, 3'd1, 3'd2, 16'h0000, 3'd3, 32'hffff_ff40);
	add_nops(1);
	add_holds(4);
	add_nops(1);
	add_insn(27, ipipe_pkg::op_and, 3'd4, 3'd3, 3'd2, 16'h0000, 3'd4, 32'h0000_1040);
	add_holds(1);
	// Hold lands right after a result strobe
	add_insn(28, ipipe_pkg::op_or, 3'd5, 3'd4, 3'd5, 16'h0000, 3'd5, 32'h0000_1163);
	add_insn(29, ipipe_pkg::op_xor, 3'd6, 3'd5, 3'd6, 16'h0000, 3'd6, 32'h0000_1535);
	add_holds(3);
	add_nops(3);

	// Execute forward beats writeback when both stages write r1
	add_insn(30, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h0001, 3'd1, 32'h0000_0001);
	add_insn(31, ipipe_pkg::op_addi, 3'd1, 3'd0, 3'd0, 16'h0002, 3'd1, 32'h0000_0002);
	add_insn(32, ipipe_pkg::op_add, 3'd2, 3'd1, 3'd0, 16'h0000, 3'd2, 32'h0000_0002);
	add_nops(3);
endtask

`endif

//--- testbench/int_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_tb;

	localparam int width          = 32;
	localparam int reset_cycles   = 16;
	localparam int timeout_cycles = 40;

	// One table row per clock cycle of stimulus
	typedef struct packed {
		logic [7:0]           test;
		logic                 hold;
		logic                 strobe;
		ipipe_pkg::insn_t     insn;
		ipipe_pkg::reg_addr_t exp_rd;
		logic [width-1:0]     exp_data;
	} step_t;

	// Result as seen on the output port
	typedef struct packed {
		ipipe_pkg::reg_addr_t rd;
		logic [width-1:0]     data;
	} result_t;

	logic                 clk;
	logic                 rst_n;
	logic                 hold;
	logic                 insn_valid;
	ipipe_pkg::insn_t     insn;
	logic                 res_valid;
	ipipe_pkg::reg_addr_t res_rd;
	logic [width-1:0]     res_data;

	step_t   table_q[$];
	step_t   expect_q[$];
	result_t result_q[$];
	int      errors;
	int      monitor_errors = 0;
	int      passed;
	int      failed;
	bit      timed_out;

	int_pipe_top #(.width(width)) int_pipe_top_inst (
		.clk(clk), .rst_n(rst_n), .hold(hold),
		.insn_valid(insn_valid), .insn(insn),
		.res_valid(res_valid), .res_rd(res_rd), .res_data(res_data)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////
	// Table construction
	////////////////////////////////////////

	task automatic add_insn(input logic [7:0] test, input ipipe_pkg::alu_op_t op,
			input ipipe_pkg::reg_addr_t rd, ra, rb, input ipipe_pkg::imm_t imm,
			input ipipe_pkg::reg_addr_t exp_rd, input logic [width-1:0] exp_data);
		step_t s;
		s          = '0;
		s.test     = test;
		s.strobe   = 1'b1;
		s.insn.op  = op;
		s.insn.rd  = rd;
		s.insn.ra  = ra;
		s.insn.rb  = rb;
		s.insn.imm = imm;
		s.exp_rd   = exp_rd;
		s.exp_data = exp_data;
		table_q.push_back(s);
	endtask

	// Idle cycles without a strobe
	task automatic add_nops(input int n);
		for (int k = 0; k < n; k++) begin
			table_q.push_back(step_t'(0));
		end
	endtask

	// Frozen cycles carry no strobe
	task automatic add_holds(input int n);
		step_t s;
		s      = '0;
		s.hold = 1'b1;
		for (int k = 0; k < n; k++) begin
			table_q.push_back(s);
		end
	endtask

	`include "int_pipe_tb_vectors.svh"

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_rd(input int test, input ipipe_pkg::reg_addr_t got,
			input ipipe_pkg::reg_addr_t exp, output bit ok);
		ok = (got === exp);
		if (!ok) begin
			$display("[ERROR] test %0d res_rd got 0x%h expected 0x%h", test, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input int test, input logic [width-1:0] got,
			input logic [width-1:0] exp, output bit ok);
		ok = (got === exp);
		if (!ok) begin
			$display("[ERROR] test %0d res_data got 0x%h expected 0x%h", test, got, exp);
			errors++;
		end
	endtask

	// Result monitor pushes one entry per strobe
	always @(posedge clk) begin
		if (!rst_n) begin
			if (res_valid === 1'b1) begin
				$display("res_valid went high while reset was asserted");
				monitor_errors++;
			end
		end else if (res_valid === 1'b1) begin
			result_q.push_back({res_rd, res_data});
		end
	end

	////////////////////////////////////////
	// Stimulus and checking
	////////////////////////////////////////

	// Inputs move 5 ns after the rising edge
	task automatic apply_table();
		for (int i = 0; i < table_q.size(); i++) begin
			@(posedge clk);
			#5;
			hold       = table_q[i].hold;
			insn_valid = table_q[i].strobe;
			insn       = table_q[i].insn;
		end
		@(posedge clk);
		#5;
		hold       = 1'b0;
		insn_valid = 1'b0;
		insn       = '0;
	endtask

	// Results must come back in issue order
	// Queue is read half a cycle after the monitor fills it
	task automatic check_results();
		int      waited;
		bit      rd_ok;
		bit      data_ok;
		step_t   e;
		result_t r;
		while (expect_q.size() != 0 && !timed_out) begin
			e      = expect_q.pop_front();
			waited = 0;
			while (result_q.size() == 0 && waited < timeout_cycles) begin
				@(negedge clk);
				waited++;
			end
			if (result_q.size() == 0) begin
				$display("test %0d: no result within timeout", e.test);
				errors++;
				failed++;
				timed_out = 1'b1;
			end else begin
				r = result_q.pop_front();
				check_rd(e.test, r.rd, e.exp_rd, rd_ok);
				check_data(e.test, r.data, e.exp_data, data_ok);
				if (rd_ok && data_ok) begin
					passed++;
				end else begin
					failed++;
				end
				$display("test %0d: rd %0d data 0x%h %s", e.test, r.rd, r.data,
					(rd_ok && data_ok) ? "ok" : "mismatch");
			end
		end
	endtask

	initial begin
		int total_errors;
		errors     = 0;
		passed     = 0;
		failed     = 0;
		timed_out  = 1'b0;
		rst_n      = 1'b0;
		hold       = 1'b0;
		insn_valid = 1'b0;
		insn       = '0;
		load_vectors();
		foreach (table_q[i]) begin
			if (table_q[i].strobe) begin
				expect_q.push_back(table_q[i]);
			end
		end

		repeat (reset_cycles) @(posedge clk);
		#5 rst_n = 1'b1;

		// Checker runs alongside the stimulus
		fork
			apply_table();
			check_results();
		join

		// Any leftover strobe is a duplicate or a stray result
		repeat (8) @(posedge clk);
		if (!timed_out && result_q.size() != 0) begin
			$display("%0d more results arrived than instructions issued", result_q.size());
			errors++;
		end

		total_errors = errors + monitor_errors;
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errors);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/int_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top #(
	parameter int width = 32
) (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   hold,
	input  wire                   insn_valid,
	input  wire ipipe_pkg::insn_t insn,
	output logic                  res_valid,
	output ipipe_pkg::reg_addr_t  res_rd,
	output logic [width-1:0]      res_data
);

	////////////////////////////////////////
	// Stage interconnect
	////////////////////////////////////////

	// Decode outputs
	ipipe_pkg::reg_addr_t rf_addr_a;
	ipipe_pkg::reg_addr_t rf_addr_b;
	ipipe_pkg::sel_t      sel_a;
	ipipe_pkg::sel_t      sel_b;
	logic [width-1:0]     simm;
	ipipe_pkg::ex_ctrl_t  ex_ctrl;

	// Register file read data
	logic [width-1:0] rf_dataa;
	logic [width-1:0] rf_datab;

	// Execute operands and result
	logic [width-1:0] operand_a;
	logic [width-1:0] operand_b;
	logic [width-1:0] ex_forw;

	// Writeback contents, also the rf write port
	logic                 wb_valid;
	ipipe_pkg::reg_addr_t wb_rd;
	logic [width-1:0]     wb_forw;

	////////////////////////////////////////
	// Blocks
	////////////////////////////////////////

	// Decode, forwarding selects, execute control
	insn_decode #(.width(width)) insn_decode_inst (
		.clk(clk), .rst_n(rst_n), .hold(hold),
		.insn_valid(insn_valid), .insn(insn),
		.wb_valid(wb_valid), .wb_rd(wb_rd),
		.rf_addr_a(rf_addr_a), .rf_addr_b(rf_addr_b),
		.sel_a(sel_a), .sel_b(sel_b),
		.simm(simm), .ex_ctrl(ex_ctrl)
	);

	// Writes come from the writeback register
	reg_file #(.width(width)) reg_file_inst (
		.clk(clk), .rst_n(rst_n),
		.addr_a(rf_addr_a), .addr_b(rf_addr_b),
		.wr_en(wb_valid), .wr_addr(wb_rd), .wr_data(wb_forw),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab)
	);

	operand_muxes #(.width(width)) operand_muxes_inst (
		.clk(clk), .rst_n(rst_n), .hold(hold),
		.rf_dataa(rf_dataa), .rf_datab(rf_datab),
		.ex_forw(ex_forw), .wb_forw(wb_forw), .simm(simm),
		.sel_a(sel_a), .sel_b(sel_b),
		.operand_a(operand_a), .operand_b(operand_b)
	);

	alu #(.width(width)) alu_inst (
		.operand_a(operand_a), .operand_b(operand_b),
		.op(ex_ctrl.op), .ex_forw(ex_forw)
	);

	writeback_stage #(.width(width)) writeback_stage_inst (
		.clk(clk), .rst_n(rst_n), .hold(hold),
		.ex_ctrl(ex_ctrl), .ex_forw(ex_forw),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_forw(wb_forw),
		.res_valid(res_valid), .res_rd(res_rd), .res_data(res_data)
	);

endmodule

`default_nettype wire

//--- source/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage #(
	parameter int width = 32
) (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      hold,
	input  wire ipipe_pkg::ex_ctrl_t ex_ctrl,
	input  wire [width-1:0]          ex_forw,
	output logic                     wb_valid,
	output ipipe_pkg::reg_addr_t     wb_rd,
	output logic [width-1:0]         wb_forw,
	output logic                     res_valid,
	output ipipe_pkg::reg_addr_t     res_rd,
	output logic [width-1:0]         res_data
);

	////////////////////////////////////////
	// Writeback register
	////////////////////////////////////////

	// Valid bit and result strobe
	// Strobe drops on held edges, contents stay
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else if (!hold) begin
			wb_valid  <= ex_ctrl.valid;
			res_valid <= ex_ctrl.valid;
		end else begin
			res_valid <= 1'b0;
		end
	end

	// Destination and result payload
	always_ff @(posedge clk) begin
		if (!hold) begin
			wb_rd   <= ex_ctrl.rd;
			wb_forw <= ex_forw;
		end
	end

	// Result port shows the writeback contents
	// wb_valid/wb_rd/wb_forw double as the register file write
	assign res_rd   = wb_rd;
	assign res_data = wb_forw;

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
	parameter int width = 32
) (
	input  wire [width-1:0]         operand_a,
	input  wire [width-1:0]         operand_b,
	input  wire ipipe_pkg::alu_op_t op,
	output logic [width-1:0]        ex_forw
);

	////////////////////////////////////////
	// Execute result
	////////////////////////////////////////

	// Purely combinational, result valid in the execute cycle
	// Sums and differences wrap at the data width
	always_comb begin
		case (op)
			// Immediate form shares the adder
			ipipe_pkg::op_add,
			ipipe_pkg::op_addi:
				ex_forw = operand_a + operand_b;
			ipipe_pkg::op_sub:
				ex_forw = operand_a - operand_b;
			ipipe_pkg::op_and:
				ex_forw = operand_a & operand_b;
			ipipe_pkg::op_or:
				ex_forw = operand_a | operand_b;
			ipipe_pkg::op_xor:
				ex_forw = operand_a ^ operand_b;
			// Unused opcodes
			default:
				ex_forw = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/operand_muxes.sv
`timescale 1ns/1ps
`default_nettype none

module operand_muxes #(
	parameter int width = 32
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  hold,
	input  wire [width-1:0]      rf_dataa,
	input  wire [width-1:0]      rf_datab,
	input  wire [width-1:0]      ex_forw,
	input  wire [width-1:0]      wb_forw,
	input  wire [width-1:0]      simm,
	input  wire ipipe_pkg::sel_t sel_a,
	input  wire ipipe_pkg::sel_t sel_b,
	output logic [width-1:0]     operand_a,
	output logic [width-1:0]     operand_b
);

	// Mux outputs in the decode cycle
	logic [width-1:0] muxed_a;
	logic [width-1:0] muxed_b;

	////////////////////////////////////////
	// Source muxes
	////////////////////////////////////////

	// Operand A, no immediate path
	always_comb begin
		case (sel_a)
			ipipe_pkg::sel_ex_forw:
				muxed_a = ex_forw;
			ipipe_pkg::sel_wb_forw:
				muxed_a = wb_forw;
			default:
				muxed_a = rf_dataa;
		endcase
	end

	// Operand B, immediate allowed
	always_comb begin
		case (sel_b)
			ipipe_pkg::sel_imm:
				muxed_b = simm;
			ipipe_pkg::sel_ex_forw:
				muxed_b = ex_forw;
			ipipe_pkg::sel_wb_forw:
				muxed_b = wb_forw;
			default:
				muxed_b = rf_datab;
		endcase
	end

	////////////////////////////////////////
	// Execute operand registers
	////////////////////////////////////////

	// Decode and execute freeze together
	// so a plain hold-enable is enough here
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			operand_a <= '0;
			operand_b <= '0;
		end else if (!hold) begin
			operand_a <= muxed_a;
			operand_b <= muxed_b;
		end
	end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
	parameter int width = 32
) (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire ipipe_pkg::reg_addr_t addr_a,
	input  wire ipipe_pkg::reg_addr_t addr_b,
	input  wire                       wr_en,
	input  wire ipipe_pkg::reg_addr_t wr_addr,
	input  wire [width-1:0]           wr_data,
	output logic [width-1:0]          rf_dataa,
	output logic [width-1:0]          rf_datab
);

	// Storage for r1..r7 only, r0 has no flops
	logic [width-1:0] regs [1:7];

	// Single write port
	// Writes to r0 are dropped
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Two combinational read ports
	// Address zero always returns zero
	assign rf_dataa = (addr_a == '0) ? '0 : regs[addr_a];
	assign rf_datab = (addr_b == '0) ? '0 : regs[addr_b];

	// No write-through here
	// Same-cycle producer is covered by writeback forwarding

endmodule

`default_nettype wire

//--- source/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode #(
	parameter int width = 32
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  hold,
	input  wire                  insn_valid,
	input  wire ipipe_pkg::insn_t insn,
	input  wire                  wb_valid,
	input  wire ipipe_pkg::reg_addr_t wb_rd,
	output ipipe_pkg::reg_addr_t rf_addr_a,
	output ipipe_pkg::reg_addr_t rf_addr_b,
	output ipipe_pkg::sel_t      sel_a,
	output ipipe_pkg::sel_t      sel_b,
	output logic [width-1:0]     simm,
	output ipipe_pkg::ex_ctrl_t  ex_ctrl
);

	localparam int imm_w = $bits(ipipe_pkg::imm_t);

	// Instruction currently in decode
	ipipe_pkg::insn_t dec_insn;
	logic             dec_valid;

	// Forwarding source for one register operand
	// Execute stage wins over writeback, r0 never forwards
	function automatic ipipe_pkg::sel_t fwd_sel(
		input ipipe_pkg::reg_addr_t src,
		input ipipe_pkg::ex_ctrl_t  ex,
		input logic                 wbv,
		input ipipe_pkg::reg_addr_t wbr
	);
		fwd_sel = ipipe_pkg::sel_rf;
		if (src != '0) begin
			if (ex.valid && ex.rd == src) begin
				fwd_sel = ipipe_pkg::sel_ex_forw;
			end else if (wbv && wbr == src) begin
				fwd_sel = ipipe_pkg::sel_wb_forw;
			end
		end
	endfunction

	////////////////////////////////////////
	// Decode register
	////////////////////////////////////////

	// Strobe sampled only on edges without hold
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
			dec_insn  <= '0;
		end else if (!hold) begin
			dec_valid <= insn_valid;
			dec_insn  <= insn;
		end
	end

	// Register file addresses straight from the decode word
	assign rf_addr_a = dec_insn.ra;
	assign rf_addr_b = dec_insn.rb;

	// Sign extension of the immediate to the data width
	assign simm = {{(width - imm_w){dec_insn.imm[imm_w-1]}}, dec_insn.imm};

	////////////////////////////////////////
	// Operand source selects
	////////////////////////////////////////

	always_comb begin
		sel_a = fwd_sel(dec_insn.ra, ex_ctrl, wb_valid, wb_rd);
		// Add-immediate takes B from the extended immediate
		if (dec_insn.op == ipipe_pkg::op_addi) begin
			sel_b = ipipe_pkg::sel_imm;
		end else begin
			sel_b = fwd_sel(dec_insn.rb, ex_ctrl, wb_valid, wb_rd);
		end
	end

	////////////////////////////////////////
	// Execute control register
	////////////////////////////////////////

	// Loads on the same edge as the operand registers
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_ctrl <= '0;
		end else if (!hold) begin
			ex_ctrl.valid <= dec_valid;
			ex_ctrl.op    <= dec_insn.op;
			ex_ctrl.rd    <= dec_insn.rd;
		end
	end

endmodule

`default_nettype wire

//--- source/ipipe_pkg.sv
`default_nettype none

package ipipe_pkg;

	////////////////////////////////////////
	// Field widths
	////////////////////////////////////////

	// Register number for eight registers with r0 hardwired to zero
	typedef logic [2:0] reg_addr_t;

	// Raw immediate field as it sits in the instruction word
	typedef logic [15:0] imm_t;

	////////////////////////////////////////
	// Encodings
	////////////////////////////////////////

	// ALU operations
	// Register-register forms come first and add-immediate last
	typedef enum logic [2:0] {
		op_add  = 3'd0,
		op_sub  = 3'd1,
		op_and  = 3'd2,
		op_or   = 3'd3,
		op_xor  = 3'd4,
		op_addi = 3'd5
	} alu_op_t;

	// Operand source select
	// Codes run rf, imm, ex forward, wb forward
	typedef enum logic [1:0] {
		sel_rf      = 2'd0,
		sel_imm     = 2'd1,
		sel_ex_forw = 2'd2,
		sel_wb_forw = 2'd3
	} sel_t;

	////////////////////////////////////////
	// Bundles
	////////////////////////////////////////

	// Decoded instruction word of 28 bits
	typedef struct packed {
		alu_op_t   op;
		reg_addr_t rd;
		reg_addr_t ra;
		reg_addr_t rb;
		imm_t      imm;
	} insn_t;

	// Execute stage control of 7 bits
	// Travels from decode to the ALU and writeback
	typedef struct packed {
		logic      valid;
		alu_op_t   op;
		reg_addr_t rd;
	} ex_ctrl_t;

endpackage

`default_nettype wire
